// ==== bench/vdp_top_tb.sv ====
/* vdp front end testbench */

`timescale 1ns/1ns

module vdp_top_tb;

    localparam int H_ACTIVE_CYCLES = 848;
    localparam int LINE_CYCLES     = 1088;
    localparam int HSYNC_DELAY     = 16;
    localparam int HSYNC_CYCLES    = 112;
    localparam int ACTIVE_LINES    = 480;
    localparam int FRAME_CYCLES    = 517 * LINE_CYCLES;
    localparam int VSYNC_DELAY     = 6 * LINE_CYCLES;
    localparam int VSYNC_CYCLES    = 8 * LINE_CYCLES;
    localparam int HS_LIMIT        = 32;
    localparam int WATCHDOG_CYCLES = 6 * FRAME_CYCLES + 10000;
    localparam vdp_regs_pkg::axil_addr_t UNMAPPED = 8'h18;

    logic clk;
    logic reset;
    vdp_regs_pkg::axil_addr_t s_axil_awaddr;
    logic s_axil_awvalid;
    logic s_axil_awready;
    vdp_regs_pkg::axil_data_t s_axil_wdata;
    logic [3:0] s_axil_wstrb;
    logic s_axil_wvalid;
    logic s_axil_wready;
    logic [1:0] s_axil_bresp;
    logic s_axil_bvalid;
    logic s_axil_bready;
    vdp_regs_pkg::axil_addr_t s_axil_araddr;
    logic s_axil_arvalid;
    logic s_axil_arready;
    vdp_regs_pkg::axil_data_t s_axil_rdata;
    logic [1:0] s_axil_rresp;
    logic s_axil_rvalid;
    logic s_axil_rready;
    logic [11:0] vga_rgb;
    logic vga_hsync;
    logic vga_vsync;
    logic vga_de;

    int timing_errors = 0;
    int pixel_errors = 0;
    int reg_errors = 0;

    // position model built from the outputs.
    int col;
    int row;
    int vsync_falls;
    int since_de_rise;
    int since_de_fall;
    int since_hsync_fall;
    int since_vsync_fall;
    logic line_had_de;
    logic hsync_seen;
    logic vsync_seen;
    logic prev_de;
    logic prev_hsync;
    logic prev_vsync;
    logic [11:0] exp_rgb;
    logic [31:0] rd_value;

    // written config and the config shown in the current frame.
    logic pend_enable = 1'b1;
    logic [11:0] pend_a = 12'hFFF;
    logic [11:0] pend_b = 12'h000;
    logic [10:0] pend_scroll = 11'd0;
    logic [2:0] pend_shift = 3'd4;
    logic cur_enable;
    logic [11:0] cur_a;
    logic [11:0] cur_b;
    logic [10:0] cur_scroll;
    logic [2:0] cur_shift;

    vdp_top vdp_top_i (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [11:0] checker_colour(input int x, input int y);
        int cell_x;
        int cell_y;
        cell_x = ((x + cur_scroll) % 2048) >> cur_shift;
        cell_y = y >> cur_shift;
        if (cur_enable && ((cell_x ^ cell_y) & 1) == 1) begin
            return cur_b;
        end
        return cur_a;
    endfunction

    function automatic logic [31:0] field_mask(input vdp_regs_pkg::axil_addr_t addr);
        case (addr)
            vdp_regs_pkg::REG_CTRL:       return 32'h1;
            vdp_regs_pkg::REG_COLOR_A:    return 32'hFFF;
            vdp_regs_pkg::REG_COLOR_B:    return 32'hFFF;
            vdp_regs_pkg::REG_SCROLL_X:   return 32'h7FF;
            vdp_regs_pkg::REG_CELL_SHIFT: return 32'h7;
            default:                      return 32'h0;
        endcase
    endfunction

    function automatic logic [31:0] pending_value(input vdp_regs_pkg::axil_addr_t addr);
        case (addr)
            vdp_regs_pkg::REG_CTRL:       return 32'(pend_enable);
            vdp_regs_pkg::REG_COLOR_A:    return 32'(pend_a);
            vdp_regs_pkg::REG_COLOR_B:    return 32'(pend_b);
            vdp_regs_pkg::REG_SCROLL_X:   return 32'(pend_scroll);
            vdp_regs_pkg::REG_CELL_SHIFT: return 32'(pend_shift);
            default:                      return 32'h0;
        endcase
    endfunction

    task automatic apply_pending(input vdp_regs_pkg::axil_addr_t addr, input logic [31:0] value);
        case (addr)
            vdp_regs_pkg::REG_CTRL:       pend_enable = value[0];
            vdp_regs_pkg::REG_COLOR_A:    pend_a = value[11:0];
            vdp_regs_pkg::REG_COLOR_B:    pend_b = value[11:0];
            vdp_regs_pkg::REG_SCROLL_X:   pend_scroll = value[10:0];
            vdp_regs_pkg::REG_CELL_SHIFT: pend_shift = value[2:0];
            default: ;
        endcase
    endtask

    task automatic timing_is(input string name, input int got, input int exp);
        assert (got == exp) else begin
            timing_errors++;
            $display("Error: %s expected %h got %h", name, exp, got);
        end
    endtask

    task automatic register_is(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got == exp) else begin
            reg_errors++;
            $display("Error: %s expected %h got %h", name, exp, got);
        end
    endtask

    // ####################################################################
    // axi4-lite transfers.

    task automatic write_reg(input vdp_regs_pkg::axil_addr_t addr, input logic [31:0] data,
                             input logic [3:0] strb);
        int waited;
        int delay;
        logic done;
        waited = 0;
        done = 1'b0;
        delay = $urandom_range(3, 0);
        @(negedge clk);
        s_axil_awaddr  = addr;
        s_axil_wdata   = data;
        s_axil_wstrb   = strb;
        s_axil_awvalid = 1'b1;
        s_axil_wvalid  = 1'b1;
        while (!done && waited < HS_LIMIT) begin
            @(posedge clk);
            done = s_axil_awready && s_axil_wready;
            waited++;
        end
        if (!done) begin
            reg_errors++;
            $display("write address and data were never accepted");
        end
        @(negedge clk);
        s_axil_awvalid = 1'b0;
        s_axil_wvalid  = 1'b0;
        // a late bready keeps the response waiting.
        repeat (delay) @(negedge clk);
        s_axil_bready = 1'b1;
        waited = 0;
        done = 1'b0;
        while (!done && waited < HS_LIMIT) begin
            @(posedge clk);
            done = s_axil_bvalid;
            waited++;
        end
        if (!done) begin
            reg_errors++;
            $display("write response never arrived");
        end
        @(negedge clk);
        s_axil_bready = 1'b0;
    endtask

    task automatic read_reg(input vdp_regs_pkg::axil_addr_t addr, output logic [31:0] data);
        int waited;
        int delay;
        logic done;
        logic [1:0] resp;
        waited = 0;
        done = 1'b0;
        data = '0;
        resp = '0;
        delay = $urandom_range(3, 0);
        @(negedge clk);
        s_axil_araddr  = addr;
        s_axil_arvalid = 1'b1;
        while (!done && waited < HS_LIMIT) begin
            @(posedge clk);
            done = s_axil_arready;
            waited++;
        end
        if (!done) begin
            reg_errors++;
            $display("read address was never accepted");
        end
        @(negedge clk);
        s_axil_arvalid = 1'b0;
        repeat (delay) @(negedge clk);
        s_axil_rready = 1'b1;
        waited = 0;
        done = 1'b0;
        while (!done && waited < HS_LIMIT) begin
            @(posedge clk);
            done = s_axil_rvalid;
            data = s_axil_rdata;
            resp = s_axil_rresp;
            waited++;
        end
        if (!done) begin
            reg_errors++;
            $display("read data never arrived");
        end
        register_is("s_axil_rresp", 32'(resp), 32'h0);
        @(negedge clk);
        s_axil_rready = 1'b0;
    endtask

    task automatic write_and_verify(input vdp_regs_pkg::axil_addr_t addr, input logic [31:0] data,
                                    input logic [3:0] strb, input string name);
        logic [31:0] byte_mask;
        logic [31:0] expected;
        logic [31:0] got;
        byte_mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
        expected = ((pending_value(addr) & ~byte_mask) | (data & byte_mask)) & field_mask(addr);
        write_reg(addr, data, strb);
        apply_pending(addr, expected);
        read_reg(addr, got);
        register_is(name, got, expected);
    endtask

    // rows 480 to 485, before vsync falls.
    task automatic wait_vblank();
        while (row == ACTIVE_LINES) @(negedge clk);
        while (row != ACTIVE_LINES) @(negedge clk);
    endtask

    // ####################################################################
    // output model and checks.

    always @(posedge clk) begin
        if (reset) begin
            col = 0;
            row = 0;
            vsync_falls = 0;
            since_de_rise = 0;
            since_de_fall = 0;
            since_hsync_fall = 0;
            since_vsync_fall = 0;
            line_had_de = 1'b0;
            hsync_seen = 1'b0;
            vsync_seen = 1'b0;
            prev_de = 1'b0;
            prev_hsync = 1'b1;
            prev_vsync = 1'b1;
            cur_enable = 1'b1;
            cur_a = 12'hFFF;
            cur_b = 12'h000;
            cur_scroll = 11'd0;
            cur_shift = 3'd4;
        end else begin
            since_de_rise++;
            since_de_fall++;
            since_hsync_fall++;
            since_vsync_fall++;
            if (vga_de) begin
                exp_rgb = checker_colour(col, row);
                assert (vga_rgb == exp_rgb) else begin
                    pixel_errors++;
                    $display("Error: vga_rgb at column %0d row %0d expected %h got %h",
                             col, row, exp_rgb, vga_rgb);
                end
                col++;
            end
            if (vga_de && !prev_de) begin
                if (row > 0) begin
                    timing_is("vga_de line period", since_de_rise, LINE_CYCLES);
                end
                since_de_rise = 0;
            end
            if (!vga_de && prev_de) begin
                timing_is("vga_de active cycles", col, H_ACTIVE_CYCLES);
                col = 0;
                row++;
                since_de_fall = 0;
                line_had_de = 1'b1;
            end
            if (!vga_hsync && prev_hsync) begin
                if (line_had_de) begin
                    timing_is("vga_hsync delay after vga_de", since_de_fall, HSYNC_DELAY);
                end
                if (hsync_seen) begin
                    timing_is("vga_hsync period", since_hsync_fall, LINE_CYCLES);
                end
                hsync_seen = 1'b1;
                line_had_de = 1'b0;
                since_hsync_fall = 0;
            end
            if (vga_hsync && !prev_hsync) begin
                timing_is("vga_hsync low cycles", since_hsync_fall, HSYNC_CYCLES);
            end
            if (!vga_vsync && prev_vsync) begin
                timing_is("vga_de lines per frame", row, ACTIVE_LINES);
                timing_is("vga_vsync delay after last line", since_de_fall, VSYNC_DELAY);
                if (vsync_seen) begin
                    timing_is("vga_vsync period", since_vsync_fall, FRAME_CYCLES);
                end
                vsync_seen = 1'b1;
                vsync_falls++;
                since_vsync_fall = 0;
                row = 0;
                // next frame shows what was written in this blanking.
                cur_enable = pend_enable;
                cur_a = pend_a;
                cur_b = pend_b;
                cur_scroll = pend_scroll;
                cur_shift = pend_shift;
            end
            if (vga_vsync && !prev_vsync) begin
                timing_is("vga_vsync low cycles", since_vsync_fall, VSYNC_CYCLES);
            end
            prev_de = vga_de;
            prev_hsync = vga_hsync;
            prev_vsync = vga_vsync;
        end
    end

    blank_without_de: assert property (@(posedge clk) disable iff (reset)
        !vga_de |-> vga_rgb == 12'h000)
        else begin
            pixel_errors++;
            $display("Error: vga_rgb expected %h got %h with vga_de low", 12'h000,
                     $sampled(vga_rgb));
        end

    no_sync_in_active: assert property (@(posedge clk) disable iff (reset)
        vga_de |-> vga_hsync && vga_vsync)
        else begin
            timing_errors++;
            $display("sync pulse overlaps active display");
        end

    bresp_okay: assert property (@(posedge clk) disable iff (reset)
        s_axil_bvalid |-> s_axil_bresp == 2'b00)
        else begin
            reg_errors++;
            $display("Error: s_axil_bresp expected %h got %h", 2'b00, $sampled(s_axil_bresp));
        end

    // ####################################################################
    // sequence.

    initial begin
        void'($urandom(87));
        reset = 1'b1;
        s_axil_awaddr = '0;
        s_axil_awvalid = 1'b0;
        s_axil_wdata = '0;
        s_axil_wstrb = '0;
        s_axil_wvalid = 1'b0;
        s_axil_bready = 1'b0;
        s_axil_araddr = '0;
        s_axil_arvalid = 1'b0;
        s_axil_rready = 1'b0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        register_is("vga_hsync", 32'(vga_hsync), 32'h1);
        register_is("vga_vsync", 32'(vga_vsync), 32'h1);
        register_is("vga_de", 32'(vga_de), 32'h0);
        register_is("vga_rgb", 32'(vga_rgb), 32'h0);
        register_is("s_axil_awready", 32'(s_axil_awready), 32'h0);
        register_is("s_axil_wready", 32'(s_axil_wready), 32'h0);
        register_is("s_axil_arready", 32'(s_axil_arready), 32'h0);
        register_is("s_axil_bvalid", 32'(s_axil_bvalid), 32'h0);
        register_is("s_axil_rvalid", 32'(s_axil_rvalid), 32'h0);
        reset = 1'b0;

        // frame 0 runs on the defaults.
        wait_vblank();
        read_reg(vdp_regs_pkg::REG_FRAME_COUNT, rd_value);
        register_is("frame_count", rd_value, 32'(vsync_falls));
        read_reg(UNMAPPED, rd_value);
        register_is("unmapped offset", rd_value, 32'h0);
        write_and_verify(vdp_regs_pkg::REG_CTRL, $urandom | 32'h1, 4'hF, "ctrl");
        write_and_verify(vdp_regs_pkg::REG_COLOR_A, $urandom, 4'hF, "color_a");
        write_and_verify(vdp_regs_pkg::REG_COLOR_B, $urandom, 4'hF, "color_b");
        write_and_verify(vdp_regs_pkg::REG_SCROLL_X, $urandom, 4'hF, "scroll_x");
        write_and_verify(vdp_regs_pkg::REG_CELL_SHIFT, $urandom, 4'hF, "cell_shift");

        // frame 1 shows the random set, frame 2 is plain colour a.
        wait_vblank();
        read_reg(vdp_regs_pkg::REG_FRAME_COUNT, rd_value);
        register_is("frame_count", rd_value, 32'(vsync_falls));
        write_and_verify(vdp_regs_pkg::REG_CTRL, 32'h0, 4'hF, "ctrl");

        wait_vblank();
        write_and_verify(vdp_regs_pkg::REG_COLOR_A, $urandom, 4'hF, "color_a");
        write_and_verify(vdp_regs_pkg::REG_COLOR_A, $urandom, 4'h1, "color_a low byte");
        write_and_verify(vdp_regs_pkg::REG_COLOR_B, $urandom, 4'hF, "color_b");
        write_and_verify(vdp_regs_pkg::REG_SCROLL_X, $urandom, 4'hF, "scroll_x");
        write_and_verify(vdp_regs_pkg::REG_CELL_SHIFT, $urandom, 4'hF, "cell_shift");
        write_and_verify(vdp_regs_pkg::REG_CTRL, 32'h1, 4'hF, "ctrl");

        wait_vblank();
        read_reg(vdp_regs_pkg::REG_FRAME_COUNT, rd_value);
        register_is("frame_count", rd_value, 32'(vsync_falls));

        $display("errors: timing %0d, pixel %0d, register %0d",
                 timing_errors, pixel_errors, reg_errors);
        if (timing_errors + pixel_errors + reg_errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired before the test sequence finished");
        $display(">>> FAIL");
        $finish;
    end

endmodule

// ==== hw/vdp_axil_regs.sv ====
/* axi4-lite configuration registers */

`timescale 1ns/1ns

module vdp_axil_regs (
    input  logic clk,
    input  logic reset,
    input  vdp_regs_pkg::axil_addr_t s_axil_awaddr,
    input  logic s_axil_awvalid,
    output logic s_axil_awready,
    input  vdp_regs_pkg::axil_data_t s_axil_wdata,
    input  logic [3:0] s_axil_wstrb,
    input  logic s_axil_wvalid,
    output logic s_axil_wready,
    output logic [1:0] s_axil_bresp,
    output logic s_axil_bvalid,
    input  logic s_axil_bready,
    input  vdp_regs_pkg::axil_addr_t s_axil_araddr,
    input  logic s_axil_arvalid,
    output logic s_axil_arready,
    output vdp_regs_pkg::axil_data_t s_axil_rdata,
    output logic [1:0] s_axil_rresp,
    output logic s_axil_rvalid,
    input  logic s_axil_rready,
    input  logic frame_ended,
    vdp_config_if.master cfg
);

    logic enable;
    vdp_video_pkg::rgb_t color_a;
    vdp_video_pkg::rgb_t color_b;
    vdp_video_pkg::raster_x_t scroll_x;
    vdp_video_pkg::cell_shift_t cell_shift;
    vdp_regs_pkg::axil_data_t frame_count;
    vdp_regs_pkg::axil_data_t wr_value;
    logic wr_accept;
    logic rd_accept;

    // register contents, zero extended.
    function automatic vdp_regs_pkg::axil_data_t reg_read(input vdp_regs_pkg::axil_addr_t addr);
        case (addr)
            vdp_regs_pkg::REG_CTRL:        return vdp_regs_pkg::axil_data_t'(enable);
            vdp_regs_pkg::REG_COLOR_A:     return vdp_regs_pkg::axil_data_t'(color_a);
            vdp_regs_pkg::REG_COLOR_B:     return vdp_regs_pkg::axil_data_t'(color_b);
            vdp_regs_pkg::REG_SCROLL_X:    return vdp_regs_pkg::axil_data_t'(scroll_x);
            vdp_regs_pkg::REG_CELL_SHIFT:  return vdp_regs_pkg::axil_data_t'(cell_shift);
            vdp_regs_pkg::REG_FRAME_COUNT: return frame_count;
            default:                       return '0;
        endcase
    endfunction

    // ####################################################################
    // write channel.

    assign wr_accept      = s_axil_awvalid && s_axil_wvalid && !s_axil_bvalid;
    assign s_axil_awready = wr_accept;
    assign s_axil_wready  = wr_accept;
    assign s_axil_bresp   = vdp_regs_pkg::AXI_RESP_OKAY;

    // bytes without strobe keep their old value.
    always_comb begin
        wr_value = reg_read(s_axil_awaddr);
        for (int i = 0; i < 4; i++) begin
            if (s_axil_wstrb[i]) begin
                wr_value[8*i +: 8] = s_axil_wdata[8*i +: 8];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            enable        <= vdp_regs_pkg::DEF_ENABLE;
            color_a       <= vdp_regs_pkg::DEF_COLOR_A;
            color_b       <= vdp_regs_pkg::DEF_COLOR_B;
            scroll_x      <= vdp_regs_pkg::DEF_SCROLL_X;
            cell_shift    <= vdp_regs_pkg::DEF_CELL_SHIFT;
            s_axil_bvalid <= 1'b0;
        end else if (wr_accept) begin
            s_axil_bvalid <= 1'b1;
            case (s_axil_awaddr)
                vdp_regs_pkg::REG_CTRL:       enable     <= wr_value[0];
                vdp_regs_pkg::REG_COLOR_A:    color_a    <= vdp_video_pkg::rgb_t'(wr_value);
                vdp_regs_pkg::REG_COLOR_B:    color_b    <= vdp_video_pkg::rgb_t'(wr_value);
                vdp_regs_pkg::REG_SCROLL_X:   scroll_x   <= vdp_video_pkg::raster_x_t'(wr_value);
                vdp_regs_pkg::REG_CELL_SHIFT: cell_shift <= vdp_video_pkg::cell_shift_t'(wr_value);
                default: ;
            endcase
        end else if (s_axil_bready) begin
            s_axil_bvalid <= 1'b0;
        end
    end

    // ####################################################################
    // read channel.

    assign rd_accept      = s_axil_arvalid && !s_axil_rvalid;
    assign s_axil_arready = rd_accept;
    assign s_axil_rresp   = vdp_regs_pkg::AXI_RESP_OKAY;

    always_ff @(posedge clk) begin
        if (reset) begin
            s_axil_rvalid <= 1'b0;
        end else if (rd_accept) begin
            s_axil_rvalid <= 1'b1;
        end else if (s_axil_rready) begin
            s_axil_rvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_accept) begin
            s_axil_rdata <= reg_read(s_axil_araddr);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            frame_count <= '0;
        end else if (frame_ended) begin
            frame_count <= frame_count + 1'b1;
        end
    end

    assign cfg.enable     = enable;
    assign cfg.color_a    = color_a;
    assign cfg.color_b    = color_b;
    assign cfg.scroll_x   = scroll_x;
    assign cfg.cell_shift = cell_shift;

    bvalid_held: assert property (@(posedge clk) disable iff (reset)
        s_axil_bvalid && !s_axil_bready |=> s_axil_bvalid);

    rvalid_held: assert property (@(posedge clk) disable iff (reset)
        s_axil_rvalid && !s_axil_rready |=> s_axil_rvalid);

endmodule

// ==== hw/vdp_config_if.sv ====
/* live configuration */

`timescale 1ns/1ns

interface vdp_config_if;

    logic enable;
    vdp_video_pkg::rgb_t color_a;
    vdp_video_pkg::rgb_t color_b;
    vdp_video_pkg::raster_x_t scroll_x;
    vdp_video_pkg::cell_shift_t cell_shift;

    modport master (output enable, color_a, color_b, scroll_x, cell_shift);

    modport slave (input enable, color_a, color_b, scroll_x, cell_shift);

endinterface

// ==== hw/vdp_pattern_gen.sv ====
/* checkerboard pattern */

`timescale 1ns/1ns

module vdp_pattern_gen (
    input  logic clk,
    input  logic reset,
    vdp_timing_if.sink_pixel tim,
    vdp_config_if.slave cfg,
    output vdp_video_pkg::rgb_t pixel_rgb
);

    logic sh_enable;
    vdp_video_pkg::rgb_t sh_color_a;
    vdp_video_pkg::rgb_t sh_color_b;
    vdp_video_pkg::raster_x_t sh_scroll_x;
    vdp_video_pkg::cell_shift_t sh_cell_shift;
    vdp_video_pkg::raster_x_t column;
    vdp_video_pkg::raster_x_t scrolled_x;
    vdp_video_pkg::raster_x_t cell_x;
    vdp_video_pkg::raster_y_t cell_y;
    logic pick_b;

    // config only changes between frames.
    always_ff @(posedge clk) begin
        if (reset) begin
            sh_enable     <= vdp_regs_pkg::DEF_ENABLE;
            sh_color_a    <= vdp_regs_pkg::DEF_COLOR_A;
            sh_color_b    <= vdp_regs_pkg::DEF_COLOR_B;
            sh_scroll_x   <= vdp_regs_pkg::DEF_SCROLL_X;
            sh_cell_shift <= vdp_regs_pkg::DEF_CELL_SHIFT;
        end else if (tim.frame_ended) begin
            sh_enable     <= cfg.enable;
            sh_color_a    <= cfg.color_a;
            sh_color_b    <= cfg.color_b;
            sh_scroll_x   <= cfg.scroll_x;
            sh_cell_shift <= cfg.cell_shift;
        end
    end

    always_ff @(posedge clk) begin
        if (reset || tim.active_line_started) begin
            column <= '0;
        end else if (tim.active_display) begin
            column <= column + 1'b1;
        end
    end

    // wraps at 2048.
    assign scrolled_x = column + sh_scroll_x;
    assign cell_x     = scrolled_x >> sh_cell_shift;
    assign cell_y     = tim.raster_y >> sh_cell_shift;
    assign pick_b     = sh_enable && (cell_x[0] ^ cell_y[0]);

    always_ff @(posedge clk) begin
        pixel_rgb <= pick_b ? sh_color_b : sh_color_a;
    end

endmodule

// ==== hw/vdp_regs_pkg.sv ====
/* configuration register map */

package vdp_regs_pkg;

    typedef logic [7:0]  axil_addr_t;
    typedef logic [31:0] axil_data_t;

    localparam logic [1:0] AXI_RESP_OKAY = 2'b00;

    localparam axil_addr_t REG_CTRL        = 8'h00;
    localparam axil_addr_t REG_COLOR_A     = 8'h04;
    localparam axil_addr_t REG_COLOR_B     = 8'h08;
    localparam axil_addr_t REG_SCROLL_X    = 8'h0C;
    localparam axil_addr_t REG_CELL_SHIFT  = 8'h10;
    localparam axil_addr_t REG_FRAME_COUNT = 8'h14;

    // reset values.
    localparam logic                       DEF_ENABLE     = 1'b1;
    localparam vdp_video_pkg::rgb_t        DEF_COLOR_A    = 12'hFFF;
    localparam vdp_video_pkg::rgb_t        DEF_COLOR_B    = 12'h000;
    localparam vdp_video_pkg::raster_x_t   DEF_SCROLL_X   = 11'd0;
    localparam vdp_video_pkg::cell_shift_t DEF_CELL_SHIFT = 3'd4;

endpackage

// ==== hw/vdp_timing_if.sv ====
/* raster timing strobes */

`timescale 1ns/1ns

interface vdp_timing_if;

    vdp_video_pkg::raster_y_t raster_y;
    logic frame_ended;
    logic active_line_started;
    logic active_display;
    logic hsync;
    logic vsync;

    modport source (
        output raster_y, frame_ended, active_line_started,
        output active_display, hsync, vsync
    );

    modport sink_pixel (
        input raster_y, frame_ended, active_line_started, active_display
    );

    modport sink_out (
        input active_display, hsync, vsync
    );

endinterface

// ==== hw/vdp_top.sv ====
/* vdp video front end */

`timescale 1ns/1ns

module vdp_top (
    input  logic clk,
    input  logic reset,
    input  vdp_regs_pkg::axil_addr_t s_axil_awaddr,
    input  logic s_axil_awvalid,
    output logic s_axil_awready,
    input  vdp_regs_pkg::axil_data_t s_axil_wdata,
    input  logic [3:0] s_axil_wstrb,
    input  logic s_axil_wvalid,
    output logic s_axil_wready,
    output logic [1:0] s_axil_bresp,
    output logic s_axil_bvalid,
    input  logic s_axil_bready,
    input  vdp_regs_pkg::axil_addr_t s_axil_araddr,
    input  logic s_axil_arvalid,
    output logic s_axil_arready,
    output vdp_regs_pkg::axil_data_t s_axil_rdata,
    output logic [1:0] s_axil_rresp,
    output logic s_axil_rvalid,
    input  logic s_axil_rready,
    output vdp_video_pkg::rgb_t vga_rgb,
    output logic vga_hsync,
    output logic vga_vsync,
    output logic vga_de
);

    vdp_timing_if tim ();
    vdp_config_if cfg ();
    vdp_video_pkg::rgb_t pixel_rgb;

    vdp_vga_timing timing_i (
        .clk   (clk),
        .reset (reset),
        .tim   (tim.source)
    );

    vdp_axil_regs regs_i (
        .clk            (clk),
        .reset          (reset),
        .s_axil_awaddr  (s_axil_awaddr),
        .s_axil_awvalid (s_axil_awvalid),
        .s_axil_awready (s_axil_awready),
        .s_axil_wdata   (s_axil_wdata),
        .s_axil_wstrb   (s_axil_wstrb),
        .s_axil_wvalid  (s_axil_wvalid),
        .s_axil_wready  (s_axil_wready),
        .s_axil_bresp   (s_axil_bresp),
        .s_axil_bvalid  (s_axil_bvalid),
        .s_axil_bready  (s_axil_bready),
        .s_axil_araddr  (s_axil_araddr),
        .s_axil_arvalid (s_axil_arvalid),
        .s_axil_arready (s_axil_arready),
        .s_axil_rdata   (s_axil_rdata),
        .s_axil_rresp   (s_axil_rresp),
        .s_axil_rvalid  (s_axil_rvalid),
        .s_axil_rready  (s_axil_rready),
        .frame_ended    (tim.frame_ended),
        .cfg            (cfg.master)
    );

    vdp_pattern_gen pattern_i (
        .clk       (clk),
        .reset     (reset),
        .tim       (tim.sink_pixel),
        .cfg       (cfg.slave),
        .pixel_rgb (pixel_rgb)
    );

    vdp_vga_out out_i (
        .clk       (clk),
        .reset     (reset),
        .tim       (tim.sink_out),
        .pixel_rgb (pixel_rgb),
        .vga_rgb   (vga_rgb),
        .vga_hsync (vga_hsync),
        .vga_vsync (vga_vsync),
        .vga_de    (vga_de)
    );

endmodule

// ==== hw/vdp_vga_out.sv ====
/* vga output stage */

`timescale 1ns/1ns

module vdp_vga_out (
    input  logic clk,
    input  logic reset,
    vdp_timing_if.sink_out tim,
    input  vdp_video_pkg::rgb_t pixel_rgb,
    output vdp_video_pkg::rgb_t vga_rgb,
    output logic vga_hsync,
    output logic vga_vsync,
    output logic vga_de
);

    // first stage lines up with pixel_rgb.
    logic de_d1;
    logic hsync_d1;
    logic vsync_d1;

    always_ff @(posedge clk) begin
        if (reset) begin
            de_d1     <= 1'b0;
            hsync_d1  <= 1'b1;
            vsync_d1  <= 1'b1;
            vga_de    <= 1'b0;
            vga_hsync <= 1'b1;
            vga_vsync <= 1'b1;
            vga_rgb   <= '0;
        end else begin
            de_d1     <= tim.active_display;
            hsync_d1  <= tim.hsync;
            vsync_d1  <= tim.vsync;
            vga_de    <= de_d1;
            vga_hsync <= hsync_d1;
            vga_vsync <= vsync_d1;
            vga_rgb   <= de_d1 ? pixel_rgb : '0;
        end
    end

    blank_outside_active: assert property (@(posedge clk) disable iff (reset)
        !tim.active_display |-> ##2 (!vga_de && vga_rgb == '0));

endmodule

// ==== hw/vdp_vga_timing.sv ====
/* vga timing generator */

`timescale 1ns/1ns

module vdp_vga_timing (
    input  logic clk,
    input  logic reset,
    vdp_timing_if.source tim
);

    vdp_video_pkg::timing_state_t x_state;
    vdp_video_pkg::timing_state_t x_state_nx;
    vdp_video_pkg::timing_state_t y_state;
    vdp_video_pkg::timing_state_t y_state_nx;
    vdp_video_pkg::raster_x_t raster_x;
    vdp_video_pkg::raster_x_t raster_x_nx;
    vdp_video_pkg::raster_x_t x_target;
    vdp_video_pkg::raster_y_t raster_y_nx;
    vdp_video_pkg::raster_y_t y_target;
    logic line_end;

    // ####################################################################
    // state machines.

    always_comb begin
        case (x_state)
            vdp_video_pkg::st_fp:   x_target = vdp_video_pkg::H_FP_LAST;
            vdp_video_pkg::st_sync: x_target = vdp_video_pkg::H_SYNC_LAST;
            vdp_video_pkg::st_bp:   x_target = vdp_video_pkg::H_BP_LAST;
            default:                x_target = vdp_video_pkg::H_LAST;
        endcase
    end

    always_comb begin
        case (y_state)
            vdp_video_pkg::st_fp:   y_target = vdp_video_pkg::V_FP_LAST;
            vdp_video_pkg::st_sync: y_target = vdp_video_pkg::V_SYNC_LAST;
            vdp_video_pkg::st_bp:   y_target = vdp_video_pkg::V_LAST;
            default:                y_target = vdp_video_pkg::V_ACTIVE_LAST;
        endcase
    end

    assign line_end = (x_state == vdp_video_pkg::st_active) && (raster_x == vdp_video_pkg::H_LAST);

    always_comb begin
        x_state_nx = x_state;
        y_state_nx = y_state;
        if (raster_x == x_target) begin
            x_state_nx = vdp_video_pkg::next_state(x_state);
        end
        // vertical axis moves on line boundaries only.
        if (line_end && tim.raster_y == y_target) begin
            y_state_nx = vdp_video_pkg::next_state(y_state);
        end
    end

    always_comb begin
        raster_x_nx = raster_x + 1'b1;
        raster_y_nx = tim.raster_y;
        if (line_end) begin
            raster_x_nx = '0;
            raster_y_nx = (tim.raster_y == vdp_video_pkg::V_LAST) ? '0 : tim.raster_y + 1'b1;
        end
    end

    // ####################################################################
    // registered raster and strobes.

    always_ff @(posedge clk) begin
        if (reset) begin
            x_state                 <= vdp_video_pkg::st_fp;
            y_state                 <= vdp_video_pkg::st_active;
            raster_x                <= '0;
            tim.raster_y            <= '0;
            tim.hsync               <= 1'b1;
            tim.vsync               <= 1'b1;
            tim.active_display      <= 1'b0;
            tim.frame_ended         <= 1'b0;
            tim.active_line_started <= 1'b0;
        end else begin
            x_state            <= x_state_nx;
            y_state            <= y_state_nx;
            raster_x           <= raster_x_nx;
            tim.raster_y       <= raster_y_nx;
            tim.hsync          <= x_state_nx != vdp_video_pkg::st_sync;
            tim.vsync          <= y_state_nx != vdp_video_pkg::st_sync;
            tim.active_display <= (x_state_nx == vdp_video_pkg::st_active)
                && (y_state_nx == vdp_video_pkg::st_active);
            tim.frame_ended    <= line_end && (tim.raster_y == vdp_video_pkg::V_LAST);
            // high one cycle ahead of the first active pixel.
            tim.active_line_started <= (raster_x_nx == vdp_video_pkg::H_BP_LAST)
                && (y_state_nx == vdp_video_pkg::st_active);
        end
    end

    hsync_in_sync_state: assert property (@(posedge clk) disable iff (reset)
        !tim.hsync == (raster_x > vdp_video_pkg::H_FP_LAST
            && raster_x <= vdp_video_pkg::H_SYNC_LAST));

    frame_wraps_to_row_0: assert property (@(posedge clk) disable iff (reset)
        tim.frame_ended |=> tim.raster_y == '0);

endmodule

// ==== hw/vdp_video_pkg.sv ====
/* video timing definitions */

package vdp_video_pkg;

    // 848x480 at 60 Hz.
    localparam int H_ACTIVE     = 848;
    localparam int H_FRONTPORCH = 16;
    localparam int H_SYNC       = 112;
    localparam int H_BACKPORCH  = 112;
    localparam int H_SIZE       = H_ACTIVE + H_FRONTPORCH + H_SYNC + H_BACKPORCH;

    localparam int V_ACTIVE     = 480;
    localparam int V_FRONTPORCH = 6;
    localparam int V_SYNC       = 8;
    localparam int V_BACKPORCH  = 23;
    localparam int V_SIZE       = V_ACTIVE + V_FRONTPORCH + V_SYNC + V_BACKPORCH;

    typedef logic [10:0] raster_x_t;
    typedef logic [9:0]  raster_y_t;
    typedef logic [11:0] rgb_t;
    typedef logic [2:0]  cell_shift_t;

    typedef enum logic [1:0] {st_fp, st_sync, st_bp, st_active} timing_state_t;

    // last count of each state, line starts in front porch.
    localparam raster_x_t H_FP_LAST   = raster_x_t'(H_FRONTPORCH - 1);
    localparam raster_x_t H_SYNC_LAST = raster_x_t'(H_FRONTPORCH + H_SYNC - 1);
    localparam raster_x_t H_BP_LAST   = raster_x_t'(H_FRONTPORCH + H_SYNC + H_BACKPORCH - 1);
    localparam raster_x_t H_LAST      = raster_x_t'(H_SIZE - 1);

    // frame starts with the active rows.
    localparam raster_y_t V_ACTIVE_LAST = raster_y_t'(V_ACTIVE - 1);
    localparam raster_y_t V_FP_LAST     = raster_y_t'(V_ACTIVE + V_FRONTPORCH - 1);
    localparam raster_y_t V_SYNC_LAST   = raster_y_t'(V_ACTIVE + V_FRONTPORCH + V_SYNC - 1);
    localparam raster_y_t V_LAST        = raster_y_t'(V_SIZE - 1);

    function automatic timing_state_t next_state(input timing_state_t state);
        case (state)
            st_fp:   return st_sync;
            st_sync: return st_bp;
            st_bp:   return st_active;
            default: return st_fp;
        endcase
    endfunction

endpackage

// ==== vdp_top.f ====
hw/vdp_video_pkg.sv
hw/vdp_regs_pkg.sv
hw/vdp_timing_if.sv
hw/vdp_config_if.sv
hw/vdp_vga_timing.sv
hw/vdp_axil_regs.sv
hw/vdp_pattern_gen.sv
hw/vdp_vga_out.sv
hw/vdp_top.sv
bench/vdp_top_tb.sv
